/* Makefile */
SIM   = verilator
FLAGS = --binary --timing --assert
TOP   = audio_eq_tb
FLIST = list.f
BUILD = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD)

/* list.f */
source/audio_eq_pkg.sv
source/i2s_rx.sv
source/apb_regs.sv
source/fir_band.sv
source/eq_mixer.sv
source/i2s_tx.sv
source/audio_eq_top.sv
tests/audio_eq_asserts.sv
tests/audio_eq_tb.sv

/* source/apb_regs.sv */
`timescale 1ns/1ps

module apb_regs import audio_eq_pkg::*; (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [7:0]                       paddr,
    input  logic [31:0]                      pwdata,
    output logic [31:0]                      prdata,
    output logic                             pready,
    output logic                             pslverr,
    output logic                             enable,
    output logic                             bypass,
    output logic [NUM_BANDS-1:0]             coef_wr,     // one hot band select
    output logic [TAP_IDX_W-1:0]             coef_tap,
    output logic [COEF_W-1:0]                coef_data,
    output logic [NUM_BANDS-1:0][GAIN_W-1:0] gains
);

    apb_word_u             wword;       // write data decoded
    apb_word_u             rword;       // read data built
    logic                  access;      // apb access phase
    logic                  wr_en;
    logic                  gain_hit;
    logic [BAND_IDX_W-1:0] gain_sel;
    logic                  addr_hit;

    assign wword   = pwdata;
    assign access  = psel & penable;
    assign wr_en   = access & pwrite;
    assign pready  = access;                 // no wait states
    assign pslverr = access & ~addr_hit;     // unmapped offset
    assign prdata  = rword;

    ////////////////////////////////////////
    // address decode and read mux
    ////////////////////////////////////////
    always_comb begin
        gain_hit = 1'b0;
        gain_sel = '0;
        for (int b = 0; b < NUM_BANDS; b++) begin
            if (paddr == ADDR_GAIN0 + 8'(4 * b)) begin
                gain_hit = 1'b1;
                gain_sel = BAND_IDX_W'(b);
            end
        end
        addr_hit = gain_hit || (paddr == ADDR_CTRL) || (paddr == ADDR_COEF);
    end

    always_comb begin
        rword = '0;                          // coef offset reads zero
        if (paddr == ADDR_CTRL) begin
            rword.ctrl.enable = enable;
            rword.ctrl.bypass = bypass;
        end else if (gain_hit) begin
            rword = 32'(gains[gain_sel]);
        end
    end

    ////////////////////////////////////////
    // register writes
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            enable  <= 1'b0;
            bypass  <= 1'b0;
            coef_wr <= '0;
            gains   <= {NUM_BANDS{GAIN_UNITY}};    // unity gain
        end else begin
            coef_wr <= '0;                         // single cycle pulse
            if (wr_en && paddr == ADDR_CTRL) begin
                enable <= wword.ctrl.enable;
                bypass <= wword.ctrl.bypass;
            end
            if (wr_en && paddr == ADDR_COEF) begin
                coef_wr <= NUM_BANDS'(1) << wword.coef.band;
            end
            if (wr_en && gain_hit) begin
                gains[gain_sel] <= pwdata[GAIN_W-1:0];
            end
        end
    end

    // qualified by coef_wr in the bands
    always_ff @(posedge clk) begin
        if (wr_en && paddr == ADDR_COEF) begin
            coef_tap  <= wword.coef.tap;
            coef_data <= wword.coef.data;
        end
    end

endmodule

/* source/audio_eq_pkg.sv */
package audio_eq_pkg;

    localparam int SAMPLE_W   = 16;                  // signed pcm
    localparam int COEF_W     = 16;                  // signed q1.15
    localparam int NUM_TAPS   = 4;
    localparam int NUM_BANDS  = 4;
    localparam int BAND_W     = 20;                  // band filter output
    localparam int GAIN_W     = 8;                   // unsigned q1.7
    localparam int TAP_IDX_W  = $clog2(NUM_TAPS);
    localparam int BAND_IDX_W = $clog2(NUM_BANDS);
    localparam int ACC_W      = SAMPLE_W + COEF_W + TAP_IDX_W;       // fir mac
    localparam int MIX_W      = BAND_W + GAIN_W + 1 + BAND_IDX_W;    // gain sum

    localparam logic [GAIN_W-1:0] GAIN_UNITY = GAIN_W'(128);

    // apb register map
    localparam logic [7:0] ADDR_CTRL  = 8'h00;
    localparam logic [7:0] ADDR_COEF  = 8'h04;
    localparam logic [7:0] ADDR_GAIN0 = 8'h10;       // band b at +4*b

    // one apb data word, seen as coefficient entry or as control bits
    typedef union packed {
        struct packed {
            logic [31-BAND_IDX_W-TAP_IDX_W-COEF_W:0] rsvd;
            logic [BAND_IDX_W-1:0]                   band;   // target filter
            logic [TAP_IDX_W-1:0]                    tap;
            logic [COEF_W-1:0]                       data;   // q1.15 value
        } coef;
        struct packed {
            logic [29:0] rsvd;
            logic        bypass;                     // raw samples to dac
            logic        enable;                     // audio on
        } ctrl;
    } apb_word_u;

endpackage

/* source/audio_eq_top.sv */
`timescale 1ns/1ps

module audio_eq_top import audio_eq_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        i2s_bclk,
    input  logic        i2s_lrclk,
    input  logic        i2s_sdata,
    output logic        dac_bclk,
    output logic        dac_lrclk,
    output logic        dac_sdata,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic                             enable;
    logic                             bypass;
    logic [NUM_BANDS-1:0]             coef_wr;
    logic [TAP_IDX_W-1:0]             coef_tap;
    logic [COEF_W-1:0]                coef_data;
    logic [NUM_BANDS-1:0][GAIN_W-1:0] gains;
    logic [SAMPLE_W-1:0]              sample;
    logic                             sample_right;
    logic                             sample_valid;
    logic [NUM_BANDS-1:0][BAND_W-1:0] band_outs;
    logic [NUM_BANDS-1:0]             band_valid;     // identical timing per band
    logic [SAMPLE_W-1:0]              mix;
    logic                             mix_right;
    logic                             mix_valid;

    i2s_rx u_rx (
        .clk          (clk),
        .arst_n       (arst_n),
        .enable       (enable),
        .i2s_bclk     (i2s_bclk),
        .i2s_lrclk    (i2s_lrclk),
        .i2s_sdata    (i2s_sdata),
        .sample       (sample),
        .sample_right (sample_right),
        .sample_valid (sample_valid)
    );

    apb_regs u_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .enable    (enable),
        .bypass    (bypass),
        .coef_wr   (coef_wr),
        .coef_tap  (coef_tap),
        .coef_data (coef_data),
        .gains     (gains)
    );

    ////////////////////////////////////////
    // band filter bank
    ////////////////////////////////////////
    for (genvar b = 0; b < NUM_BANDS; b++) begin : g_band
        fir_band u_band (
            .clk          (clk),
            .arst_n       (arst_n),
            .sample       (sample),
            .sample_right (sample_right),
            .sample_valid (sample_valid),
            .coef_wr      (coef_wr[b]),       // own select bit
            .coef_tap     (coef_tap),
            .coef_data    (coef_data),
            .band_out     (band_outs[b]),
            .band_valid   (band_valid[b])
        );
    end

    eq_mixer u_mixer (
        .clk          (clk),
        .arst_n       (arst_n),
        .bypass       (bypass),
        .gains        (gains),
        .sample       (sample),
        .sample_right (sample_right),
        .sample_valid (sample_valid),
        .band_outs    (band_outs),
        .band_valid   (&band_valid),
        .mix          (mix),
        .mix_right    (mix_right),
        .mix_valid    (mix_valid)
    );

    i2s_tx u_tx (
        .clk       (clk),
        .arst_n    (arst_n),
        .i2s_bclk  (i2s_bclk),            // dac clocks follow the input
        .i2s_lrclk (i2s_lrclk),
        .mix       (mix),
        .mix_right (mix_right),
        .mix_valid (mix_valid),
        .dac_bclk  (dac_bclk),
        .dac_lrclk (dac_lrclk),
        .dac_sdata (dac_sdata)
    );

endmodule

/* source/eq_mixer.sv */
`timescale 1ns/1ps

module eq_mixer import audio_eq_pkg::*; (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             bypass,
    input  logic [NUM_BANDS-1:0][GAIN_W-1:0] gains,
    input  logic [SAMPLE_W-1:0]              sample,
    input  logic                             sample_right,
    input  logic                             sample_valid,
    input  logic [NUM_BANDS-1:0][BAND_W-1:0] band_outs,
    input  logic                             band_valid,
    output logic [SAMPLE_W-1:0]              mix,
    output logic                             mix_right,
    output logic                             mix_valid
);

    logic [SAMPLE_W-1:0]     raw_q;      // bypass path
    logic                    right_q;    // channel of current sample
    logic signed [MIX_W-1:0] acc;
    logic signed [MIX_W-1:0] acc_sh;
    logic [SAMPLE_W-1:0]     sat;

    always_comb begin
        acc = '0;
        for (int b = 0; b < NUM_BANDS; b++) begin
            // gain is unsigned so zero extend before the signed multiply
            acc = acc + MIX_W'($signed(band_outs[b]) * $signed({1'b0, gains[b]}));
        end
        acc_sh = acc >>> (GAIN_W - 1);                   // q1.7 to integer
        if (acc_sh[MIX_W-1:SAMPLE_W-1] == '0 || acc_sh[MIX_W-1:SAMPLE_W-1] == '1) begin
            sat = acc_sh[SAMPLE_W-1:0];                  // fits
        end else if (acc_sh[MIX_W-1]) begin
            sat = {1'b1, {(SAMPLE_W-1){1'b0}}};          // clamp negative
        end else begin
            sat = {1'b0, {(SAMPLE_W-1){1'b1}}};          // clamp positive
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mix_valid <= 1'b0;
        end else begin
            mix_valid <= band_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sample_valid) begin
            raw_q   <= sample;
            right_q <= sample_right;
        end
        if (band_valid) begin
            mix       <= bypass ? raw_q : sat;
            mix_right <= right_q;
        end
    end

endmodule

/* source/fir_band.sv */
`timescale 1ns/1ps

module fir_band import audio_eq_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [SAMPLE_W-1:0]  sample,
    input  logic                 sample_right,
    input  logic                 sample_valid,
    input  logic                 coef_wr,        // this band only
    input  logic [TAP_IDX_W-1:0] coef_tap,
    input  logic [COEF_W-1:0]    coef_data,
    output logic [BAND_W-1:0]    band_out,
    output logic                 band_valid
);

    logic [COEF_W-1:0]       coef   [NUM_TAPS];
    logic [SAMPLE_W-1:0]     line_l [NUM_TAPS-1];    // left history
    logic [SAMPLE_W-1:0]     line_r [NUM_TAPS-1];    // right history
    logic [SAMPLE_W-1:0]     window [NUM_TAPS];      // newest first
    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] acc_sh;

    always_comb begin
        window[0] = sample;
        for (int i = 1; i < NUM_TAPS; i++) begin
            window[i] = sample_right ? line_r[i-1] : line_l[i-1];
        end
        acc = '0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            acc = acc + ACC_W'($signed(window[i]) * $signed(coef[i]));
        end
        acc_sh = acc >>> (COEF_W - 1);                // drop q1.15 fraction
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                coef[i] <= '0;
            end
            for (int i = 0; i < NUM_TAPS - 1; i++) begin
                line_l[i] <= '0;
                line_r[i] <= '0;
            end
            band_valid <= 1'b0;
        end else begin
            band_valid <= sample_valid;
            if (coef_wr) begin
                coef[coef_tap] <= coef_data;
            end
            for (int i = 0; i < NUM_TAPS - 1; i++) begin
                if (sample_valid && sample_right) begin
                    line_r[i] <= window[i];
                end
                if (sample_valid && !sample_right) begin
                    line_l[i] <= window[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample_valid) begin
            band_out <= acc_sh[BAND_W-1:0];
        end
    end

endmodule

/* source/i2s_rx.sv */
`timescale 1ns/1ps

module i2s_rx import audio_eq_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                enable,
    input  logic                i2s_bclk,
    input  logic                i2s_lrclk,
    input  logic                i2s_sdata,
    output logic [SAMPLE_W-1:0] sample,
    output logic                sample_right,
    output logic                sample_valid
);

    logic [1:0]          bclk_s;        // two flop syncs
    logic [1:0]          lrclk_s;
    logic [1:0]          sdata_s;
    logic                bclk_d;        // edge detect delay
    logic                bclk_rise;     // registered rise strobe
    logic                lrclk_r;       // aligned with bclk_rise
    logic                sdata_r;
    logic                lr_prev;       // lrclk at previous rise
    logic [4:0]          bit_cnt;       // SAMPLE_W means idle
    logic [SAMPLE_W-1:0] shift;
    logic                bit_take;
    logic                last_bit;

    assign bit_take = bclk_rise && (lrclk_r == lr_prev) && (bit_cnt != 5'(SAMPLE_W));
    assign last_bit = bit_take && (bit_cnt == 5'(SAMPLE_W - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bclk_s       <= '0;
            lrclk_s      <= '0;
            sdata_s      <= '0;
            bclk_d       <= 1'b0;
            bclk_rise    <= 1'b0;
            lrclk_r      <= 1'b0;
            sdata_r      <= 1'b0;
            lr_prev      <= 1'b0;
            bit_cnt      <= 5'(SAMPLE_W);
            sample_valid <= 1'b0;
        end else begin
            bclk_s       <= {bclk_s[0], i2s_bclk};
            lrclk_s      <= {lrclk_s[0], i2s_lrclk};
            sdata_s      <= {sdata_s[0], i2s_sdata};
            bclk_d       <= bclk_s[1];
            bclk_rise    <= bclk_s[1] & ~bclk_d;
            lrclk_r      <= lrclk_s[1];
            sdata_r      <= sdata_s[1];
            sample_valid <= enable & last_bit;    // dropped while disabled
            if (bclk_rise) begin
                lr_prev <= lrclk_r;
                if (lrclk_r != lr_prev) begin
                    bit_cnt <= '0;                // msb comes on next rise
                end else if (bit_take) begin
                    bit_cnt <= bit_cnt + 5'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bit_take) begin
            shift <= {shift[SAMPLE_W-2:0], sdata_r};  // msb first
        end
        if (last_bit) begin
            sample       <= {shift[SAMPLE_W-2:0], sdata_r};
            sample_right <= lr_prev;                  // lrclk high is right
        end
    end

endmodule

/* source/i2s_tx.sv */
`timescale 1ns/1ps

module i2s_tx import audio_eq_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                i2s_bclk,
    input  logic                i2s_lrclk,
    input  logic [SAMPLE_W-1:0] mix,
    input  logic                mix_right,
    input  logic                mix_valid,
    output logic                dac_bclk,
    output logic                dac_lrclk,
    output logic                dac_sdata
);

    logic [2:0]            bclk_s;       // sync plus one
    logic [2:0]            lrclk_s;
    logic [SAMPLE_W-1:0]   left_hold;
    logic [SAMPLE_W-1:0]   right_hold;
    logic [2*SAMPLE_W-1:0] frame;        // left then right
    logic [4:0]            bit_cnt;      // SAMPLE_W means done
    logic                  bclk_fall;
    logic                  lr_edge;

    assign dac_bclk  = bclk_s[2];        // input clocks 3 cycles late
    assign dac_lrclk = lrclk_s[2];
    assign bclk_fall = bclk_s[2] & ~bclk_s[1];    // dac_bclk falls next edge
    assign lr_edge   = lrclk_s[2] ^ lrclk_s[1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bclk_s     <= '0;
            lrclk_s    <= '0;
            left_hold  <= '0;
            right_hold <= '0;
            frame      <= '0;
            bit_cnt    <= 5'(SAMPLE_W);
            dac_sdata  <= 1'b0;
        end else begin
            bclk_s  <= {bclk_s[1:0], i2s_bclk};
            lrclk_s <= {lrclk_s[1:0], i2s_lrclk};
            if (mix_valid && mix_right) begin
                right_hold <= mix;
            end
            if (mix_valid && !mix_right) begin
                left_hold <= mix;
            end
            if (bclk_fall) begin
                if (lr_edge) begin
                    bit_cnt   <= '0;
                    dac_sdata <= 1'b0;                 // msb one bclk later
                    if (!lrclk_s[1]) begin
                        frame <= {left_hold, right_hold};   // frame start
                    end
                end else if (bit_cnt != 5'(SAMPLE_W)) begin
                    dac_sdata <= frame[2*SAMPLE_W-1];
                    frame     <= {frame[2*SAMPLE_W-2:0], 1'b0};
                    bit_cnt   <= bit_cnt + 5'd1;
                end else begin
                    dac_sdata <= 1'b0;                 // pad to half frame end
                end
            end
        end
    end

endmodule

/* tests/audio_eq_asserts.sv */
`timescale 1ns/1ps

module audio_eq_asserts import audio_eq_pkg::*; (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 psel,
    input logic                 penable,
    input logic                 pready,
    input logic                 pslverr,
    input logic [NUM_BANDS-1:0] coef_wr
);

    ready_in_access: assert property (@(posedge clk) disable iff (!arst_n)
        (psel && penable) |-> pready)
        else $error("pready low during an apb access phase");

    err_in_access: assert property (@(posedge clk) disable iff (!arst_n)
        pslverr |-> (psel && penable))
        else $error("pslverr raised outside an apb access phase");

    coef_wr_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(coef_wr))
        else $error("coef_wr selects more than one band");

endmodule

bind apb_regs audio_eq_asserts u_asserts (.*);

/* tests/audio_eq_tb.sv */
`timescale 1ns/1ps

module audio_eq_tb import audio_eq_pkg::*; ();

    localparam int BCLK_DIV   = 8;                          // clk cycles per bclk
    localparam int HALF_BCLKS = 20;
    localparam int FRAME_CYC  = 2 * HALF_BCLKS * BCLK_DIV;
    localparam int N_SHORT    = 8;
    localparam int N_RAND     = 200;
    localparam int N_SAT      = 16;
    // one flush frame per run plus the preamble
    localparam int N_FRAMES   = 1 + 2 * (N_SHORT + 1) + (N_RAND + 1) + (N_SAT + 1);
    localparam int CYC_LIMIT  = N_FRAMES * FRAME_CYC + 5000;    // apb traffic margin

    logic        clk;
    logic        arst_n;
    logic        i2s_bclk;
    logic        i2s_lrclk;
    logic        i2s_sdata;
    logic        dac_bclk;
    logic        dac_lrclk;
    logic        dac_sdata;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    integer              seed;
    int                  cyc_cnt = 0;
    logic [31:0]         outq [$];                          // dac frames with left on top
    logic                dec_lr = 1'b0;
    int                  dec_idx = 31;                      // idle until first lr edge
    logic [SAMPLE_W-1:0] dec_word;
    logic [SAMPLE_W-1:0] dec_left;
    bit                  en_m = 1'b0;                       // model of ctrl bits
    bit                  byp_m = 1'b0;
    longint              coef_m [NUM_BANDS][NUM_TAPS] = '{default: 0};
    longint              gain_m [NUM_BANDS] = '{default: 128};
    longint              hist_m [2][NUM_TAPS-1] = '{default: 0};   // per channel
    logic [SAMPLE_W-1:0] hold_m [2] = '{default: '0};

    audio_eq_top DUT (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt > CYC_LIMIT) begin
            fail_run("timeout, the expected dac frames never arrived");
        end
    end

    ////////////////////////////////////////
    // dac output decoder
    ////////////////////////////////////////
    always @(posedge dac_bclk) begin
        if (dac_lrclk != dec_lr) begin
            dec_lr  = dac_lrclk;
            dec_idx = 0;                                    // pad bit before msb
        end else begin
            dec_idx = dec_idx + 1;
            if (dec_idx <= SAMPLE_W) begin
                dec_word = {dec_word[SAMPLE_W-2:0], dac_sdata};
            end
            if (dec_idx == SAMPLE_W && !dec_lr) begin
                dec_left = dec_word;
            end else if (dec_idx == SAMPLE_W) begin
                outq.push_back({dec_left, dec_word});       // frame done on right
            end
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_sample(input string name, input logic [SAMPLE_W-1:0] exp,
                                input logic [SAMPLE_W-1:0] act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    ////////////////////////////////////////
    // apb master
    ////////////////////////////////////////
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            input logic exp_err, output logic [31:0] rdata);
        @(posedge clk);
        #1;
        psel    = 1'b1;                                     // setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
        end
        rdata = prdata;
        if (pslverr !== exp_err) begin
            fail_run($sformatf("slave error was %b at address %h, expected %b",
                               pslverr, addr, exp_err));
        end
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_ctrl(input bit en, input bit byp);
        apb_word_u   w;
        logic [31:0] rd;
        w             = '0;
        w.ctrl.enable = en;
        w.ctrl.bypass = byp;
        apb_xfer(1'b1, ADDR_CTRL, w, 1'b0, rd);
        en_m  = en;
        byp_m = byp;
    endtask

    task automatic write_gain(input int b, input logic [GAIN_W-1:0] g);
        logic [31:0] rd;
        apb_xfer(1'b1, ADDR_GAIN0 + 8'(4 * b), 32'(g), 1'b0, rd);
        gain_m[b] = longint'(g);                            // unsigned q1.7
    endtask

    task automatic write_coef(input int b, input int t, input logic [COEF_W-1:0] c);
        apb_word_u   w;
        logic [31:0] rd;
        w           = '0;
        w.coef.band = BAND_IDX_W'(b);
        w.coef.tap  = TAP_IDX_W'(t);
        w.coef.data = c;
        apb_xfer(1'b1, ADDR_COEF, w, 1'b0, rd);
        coef_m[b][t] = longint'($signed(c));
    endtask

    ////////////////////////////////////////
    // reference model and i2s source
    ////////////////////////////////////////
    task automatic model_sample(input int ch, input logic [SAMPLE_W-1:0] s);
        longint win [NUM_TAPS];
        longint band;
        longint tot;
        if (!en_m) begin
            return;                                         // receiver drops it
        end
        win[0] = longint'($signed(s));
        for (int i = 1; i < NUM_TAPS; i++) begin
            win[i] = hist_m[ch][i-1];
        end
        tot = 0;
        for (int b = 0; b < NUM_BANDS; b++) begin
            band = 0;
            for (int i = 0; i < NUM_TAPS; i++) begin
                band = band + win[i] * coef_m[b][i];
            end
            tot = tot + (band >>> (COEF_W - 1)) * gain_m[b];
        end
        tot = tot >>> (GAIN_W - 1);
        if (tot > 32767) begin
            tot = 32767;
        end else if (tot < -32768) begin
            tot = -32768;
        end
        for (int i = 0; i < NUM_TAPS - 1; i++) begin
            hist_m[ch][i] = win[i];                         // newest sample first
        end
        hold_m[ch] = byp_m ? s : SAMPLE_W'(tot);
    endtask

    function automatic logic [SAMPLE_W-1:0] rand_sample(input bit full);
        logic [31:0] rnd;
        rnd = $random(seed);
        if (full) begin
            return rnd[0] ? 16'h7fff : 16'h8000;            // full scale either way
        end
        return rnd[SAMPLE_W-1:0];
    endfunction

    task automatic send_half(input logic lr, input logic [SAMPLE_W-1:0] word);
        for (int i = 0; i < HALF_BCLKS; i++) begin
            @(posedge clk);
            #1;
            i2s_bclk  = 1'b0;                               // data moves on fall
            i2s_lrclk = lr;
            i2s_sdata = (i >= 1 && i <= SAMPLE_W) ? word[SAMPLE_W-i] : 1'b0;
            repeat (BCLK_DIV / 2 - 1) @(posedge clk);
            @(posedge clk);
            #1;
            i2s_bclk = 1'b1;
            repeat (BCLK_DIV / 2 - 1) @(posedge clk);
        end
    endtask

    task automatic run_frames(input string name, input int n, input bit full);
        logic [SAMPLE_W-1:0] l;
        logic [SAMPLE_W-1:0] r;
        logic [SAMPLE_W-1:0] exp_l [$];
        logic [SAMPLE_W-1:0] exp_r [$];
        outq.delete();
        for (int k = 0; k <= n; k++) begin
            l = (k < n) ? rand_sample(full) : '0;           // last frame flushes
            r = (k < n) ? rand_sample(full) : '0;
            model_sample(0, l);
            model_sample(1, r);
            exp_l.push_back(hold_m[0]);
            exp_r.push_back(hold_m[1]);
            send_half(1'b0, l);
            send_half(1'b1, r);
        end
        while (outq.size() <= n) begin
            @(posedge clk);
        end
        for (int k = 0; k < n; k++) begin                   // dac frame k+1 holds input k
            check_sample($sformatf("%s frame %0d left", name, k), exp_l[k],
                         outq[k+1][2*SAMPLE_W-1:SAMPLE_W]);
            check_sample($sformatf("%s frame %0d right", name, k), exp_r[k],
                         outq[k+1][SAMPLE_W-1:0]);
        end
    endtask

    initial begin
        logic [31:0]       rd;
        logic [COEF_W-1:0] c;
        seed      = 32'hce5c_0c71;
        clk       = 1'b0;
        arst_n    = 1'b0;
        i2s_bclk  = 1'b0;
        i2s_lrclk = 1'b0;
        i2s_sdata = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        send_half(1'b1, '0);                                // so frames open on lrclk fall

        // register map
        write_ctrl(1'b0, 1'b1);
        apb_xfer(1'b0, ADDR_CTRL, '0, 1'b0, rd);
        check_word("ctrl readback", 32'h2, rd);
        for (int b = 0; b < NUM_BANDS; b++) begin
            write_gain(b, 8'($random(seed)));
        end
        for (int b = 0; b < NUM_BANDS; b++) begin
            apb_xfer(1'b0, ADDR_GAIN0 + 8'(4 * b), '0, 1'b0, rd);
            check_word($sformatf("gain %0d readback", b), 32'(gain_m[b]), rd);
        end
        apb_xfer(1'b0, ADDR_COEF, '0, 1'b0, rd);
        check_word("coef readback", 32'h0, rd);
        apb_xfer(1'b0, 8'h08, '0, 1'b1, rd);                // holes in the map
        apb_xfer(1'b1, 8'h20, 32'hffff_ffff, 1'b1, rd);
        apb_xfer(1'b0, 8'hfc, '0, 1'b1, rd);

        // bypass stays on so any leaked sample reaches the dac
        run_frames("disabled", N_SHORT, 1'b0);
        write_ctrl(1'b1, 1'b1);
        run_frames("bypass", N_SHORT, 1'b0);

        // small random filters keep most sums in range
        for (int b = 0; b < NUM_BANDS; b++) begin
            for (int t = 0; t < NUM_TAPS; t++) begin
                rd = $random(seed);
                c  = COEF_W'($signed(rd[COEF_W-1:0]) >>> 2);
                write_coef(b, t, c);
            end
            write_gain(b, 8'($random(seed)));
        end
        write_ctrl(1'b1, 1'b0);
        run_frames("random", N_RAND, 1'b0);

        // unity tap0 and max gain clamp every full scale input
        for (int b = 0; b < NUM_BANDS; b++) begin
            for (int t = 0; t < NUM_TAPS; t++) begin
                write_coef(b, t, (t == 0) ? 16'h7fff : 16'h0000);
            end
            write_gain(b, 8'hff);
        end
        run_frames("saturate", N_SAT, 1'b1);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
